//--- run.sh
#!/bin/sh
# builds the branch front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tbBranchPipe -f src.f -o simBranchPipe
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simBranchPipe > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- src.f
src/branchPkg.sv
src/stageIf.sv
src/pfb0Predictor.sv
src/dcdResolver.sv
src/exeCorrector.sv
src/branchPipe.sv
testbench/branchChecker.sv
testbench/tbBranchPipe.sv

//--- src/branchPipe.sv
`timescale 1ns/1ps
`default_nettype none

module branchPipe (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetchValid,
  input  branchPkg::instrT fetchInstr,
  input  logic             hold,
  input  logic             flush,
  input  logic             dcdCondOk,
  input  logic             exeCondOk,
  output logic             pfb0Target,
  output logic             dcdCorrect,
  output logic             exeCorrect,
  output logic             branchTarCrt
);

  ////////////////////////////////////////
  // stage links
  ////////////////////////////////////////
  stageIf   pfb0ToDcd ();
  stageIf   dcdToExe ();
  exePendIf exePend ();

  // dcd register writes, looked at by the pfb0 veto
  logic dcdLrPending;
  logic dcdCtrPending;

  pfb0Predictor uPfb0 (
    .clk           (clk),
    .rst           (rst),
    .fetchValid    (fetchValid),
    .fetchInstr    (fetchInstr),
    .hold          (hold),
    .flush         (flush),
    .pend          (exePend.dst),
    .dcdLrPending  (dcdLrPending),
    .dcdCtrPending (dcdCtrPending),
    .toDcd         (pfb0ToDcd.src),
    .pfb0Target    (pfb0Target)
  );

  dcdResolver uDcd (
    .clk           (clk),
    .rst           (rst),
    .hold          (hold),
    .flush         (flush),
    .fromPfb0      (pfb0ToDcd.dst),
    .pend          (exePend.dst),
    .dcdCondOk     (dcdCondOk),
    .toExe         (dcdToExe.src),
    .dcdLrPending  (dcdLrPending),
    .dcdCtrPending (dcdCtrPending),
    .dcdCorrect    (dcdCorrect)
  );

  exeCorrector uExe (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .fromDcd    (dcdToExe.dst),
    .pend       (exePend.src),
    .exeCondOk  (exeCondOk),
    .exeCorrect (exeCorrect)
  );

  // fetch has to redirect whenever any stage either targets or corrects
  assign branchTarCrt = pfb0Target | dcdCorrect | exeCorrect;

endmodule

`default_nettype wire

//--- src/branchPkg.sv
`default_nettype none

package branchPkg;

  // field widths of the branch instruction encoding
  localparam int boW   = 5;
  localparam int sprnW = 10;

  // bit 0 is the most significant bit, as in the architecture books
  typedef logic [0:boW-1]   boT;
  // the two 5-bit halves are already swapped back into the natural SPR number
  typedef logic [0:sprnW-1] sprnT;

  localparam sprnT sprLr  = 10'd8;
  localparam sprnT sprCtr = 10'd9;

  // one decoded instruction as it travels down the front end
  typedef struct packed {
    logic isB;
    logic isBc;
    logic isMtspr;
    logic updatesCr;
    logic priOp5;
    logic secOp0;
    logic lk;
    boT   bo;
    logic bd0;
    sprnT sprn;
  } instrT;

  // occupancy of a stage register
  typedef enum logic {empty = 1'b0, full = 1'b1} stageState;

  ////////////////////////////////////////
  // decode helpers shared by the stages
  ////////////////////////////////////////

  // priOp5 marks a branch through a register and secOp0 picks which one
  function automatic logic isBclr(input instrT ins);
    return ins.priOp5 & ~ins.secOp0;
  endfunction

  function automatic logic isBcctr(input instrT ins);
    return ins.priOp5 & ins.secOp0;
  endfunction

  function automatic logic movesCtr(input instrT ins);
    return ins.isMtspr & (ins.sprn == sprCtr);
  endfunction

  // an mtspr to LR or any branch that links rewrites LR
  function automatic logic writesLr(input instrT ins);
    return (ins.isMtspr & (ins.sprn == sprLr)) | ((ins.isB | ins.isBc) & ins.lk);
  endfunction

  // a conditional branch with BO2 clear decrements CTR on its way through
  function automatic logic writesCtr(input instrT ins);
    return movesCtr(ins) | (ins.isBc & ~ins.bo[2]);
  endfunction

endpackage

`default_nettype wire

//--- src/dcdResolver.sv
`timescale 1ns/1ps
`default_nettype none

module dcdResolver (
  input  logic  clk,
  input  logic  rst,
  input  logic  hold,
  input  logic  flush,
  stageIf.dst   fromPfb0,
  exePendIf.dst pend,
  input  logic  dcdCondOk,
  stageIf.src   toExe,
  output logic  dcdLrPending,
  output logic  dcdCtrPending,
  output logic  dcdCorrect
);
  import branchPkg::*;

  stageState dcdState;
  instrT     dcdInstr;
  // direction this branch got in pfb0
  logic      pfbPred;
  logic      firstCycle;
  logic      predictHolding;
  logic      isFull;
  logic      isBcFull;
  logic      predict;
  logic      predictQ;
  logic      savedPredict;

  assign isFull   = (dcdState == full);
  assign isBcFull = isFull & dcdInstr.isBc;

  // register writes by the instruction sitting in dcd, seen by pfb0
  assign dcdLrPending  = isFull & writesLr(dcdInstr);
  assign dcdCtrPending = isFull & writesCtr(dcdInstr);

  ////////////////////////////////////////
  // predict decision
  ////////////////////////////////////////

  // the condition cannot be resolved yet when exe still changes what it reads
  assign predict = (~dcdInstr.bo[0] & pend.crUpdate) |
                   (~dcdInstr.bo[2] & pend.mtCtr) |
                   (isBclr(dcdInstr) & pend.lrUpdate) |
                   (isBcctr(dcdInstr) & pend.ctrUpForBcctr);

  assign predictQ = predict & isBcFull;

  // predict from the first cycle is what exe sees, even after a long hold
  assign savedPredict = firstCycle ? predictQ : predictHolding;

  // resolved here and pfb0 guessed the other way
  assign dcdCorrect = isBcFull & firstCycle & ~predict & (pfbPred ^ dcdCondOk);

  // a predicting branch keeps its pfb0 direction into exe
  assign toExe.full     = isFull;
  assign toExe.instr    = dcdInstr;
  assign toExe.pred     = savedPredict;
  assign toExe.fromPfb0 = pfbPred;

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dcdState       <= empty;
      firstCycle     <= 1'b1;
      predictHolding <= 1'b0;
    end
    else
    begin
      firstCycle     <= flush | ~(isFull & hold);
      predictHolding <= savedPredict;
      // flush wins over hold
      if (flush)
        dcdState <= empty;
      else if (!hold)
        dcdState <= fromPfb0.full ? full : empty;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!hold)
    begin
      dcdInstr <= fromPfb0.instr;
      // already qualified with bc and full in pfb0
      pfbPred  <= fromPfb0.pred;
    end
  end

endmodule

`default_nettype wire

//--- src/exeCorrector.sv
`timescale 1ns/1ps
`default_nettype none

module exeCorrector (
  input  logic  clk,
  input  logic  rst,
  input  logic  hold,
  stageIf.dst   fromDcd,
  exePendIf.src pend,
  input  logic  exeCondOk,
  output logic  exeCorrect
);
  import branchPkg::*;

  stageState exeState;
  instrT     exeInstr;
  // dcd could not resolve this branch
  logic      exePredict;
  // direction that was assumed while predicting
  logic      exeDir;
  logic      isFull;

  assign isFull = (exeState == full);

  // exe never holds, so a full exe is always in its first cycle
  // and the full bit stands in for the first-cycle bit

  ////////////////////////////////////////
  // pending updates fed back upstream
  ////////////////////////////////////////
  assign pend.lrUpdate      = isFull & writesLr(exeInstr);
  assign pend.ctrUpForBcctr = isFull & writesCtr(exeInstr);
  assign pend.mtCtr         = isFull & movesCtr(exeInstr);
  assign pend.crUpdate      = isFull & exeInstr.updatesCr;

  // every condition is known by now, so only a predicting branch can be wrong
  assign exeCorrect = isFull & exeInstr.isBc & exePredict & (exeDir ^ exeCondOk);

  always_ff @(posedge clk)
  begin
    if (rst)
      exeState <= empty;
    else if (hold)
      // dcd keeps its instruction, exe takes a bubble
      exeState <= empty;
    else
      exeState <= fromDcd.full ? full : empty;
  end

  always_ff @(posedge clk)
  begin
    exeInstr   <= fromDcd.instr;
    exePredict <= fromDcd.pred;
    exeDir     <= fromDcd.fromPfb0;
  end

endmodule

`default_nettype wire

//--- src/pfb0Predictor.sv
`timescale 1ns/1ps
`default_nettype none

module pfb0Predictor (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetchValid,
  input  branchPkg::instrT fetchInstr,
  input  logic             hold,
  input  logic             flush,
  exePendIf.dst            pend,
  input  logic             dcdLrPending,
  input  logic             dcdCtrPending,
  stageIf.src              toDcd,
  output logic             pfb0Target
);
  import branchPkg::*;

  stageState pfbState;
  instrT     pfbInstr;
  logic      firstCycle;
  logic      predHolding;
  logic      isFull;
  logic      staticTaken;
  logic      vetoed;
  logic      predQ;
  logic      savedPred;

  assign isFull = (pfbState == full);

  // static prediction from BO and the sign of the displacement
  assign staticTaken = (pfbInstr.bo[0] & pfbInstr.bo[2]) | (pfbInstr.bd0 ^ pfbInstr.bo[4]);

  // a branch through LR or CTR is guessed not taken while an older
  // instruction in dcd or exe is still rewriting that register
  assign vetoed = (isBclr(pfbInstr) & (dcdLrPending | pend.lrUpdate)) |
                  (isBcctr(pfbInstr) & (dcdCtrPending | pend.ctrUpForBcctr));

  assign predQ = staticTaken & ~vetoed & pfbInstr.isBc & isFull;

  // the redirect goes out once, in the cycle the instruction arrives
  assign pfb0Target = ((pfbInstr.isB & isFull) | predQ) & firstCycle;

  // after the first cycle the pending flags may have moved on,
  // so dcd gets the value that was used for the target
  assign savedPred = firstCycle ? predQ : predHolding;

  assign toDcd.full     = isFull;
  assign toDcd.instr    = pfbInstr;
  assign toDcd.pred     = savedPred;
  assign toDcd.fromPfb0 = 1'b0;

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pfbState    <= empty;
      firstCycle  <= 1'b1;
      predHolding <= 1'b0;
    end
    else
    begin
      // a full stage that holds is no longer in its first cycle
      firstCycle  <= flush | ~(isFull & hold);
      predHolding <= savedPred;
      if (flush)
        pfbState <= empty;
      else if (!hold)
        pfbState <= fetchValid ? full : empty;
    end
  end

  // instruction bits only matter when the state says full
  always_ff @(posedge clk)
  begin
    if (!hold)
      pfbInstr <= fetchInstr;
  end

endmodule

`default_nettype wire

//--- src/stageIf.sv
`timescale 1ns/1ps
`default_nettype none

// one stage hands its instruction and its saved prediction state to the next
interface stageIf;
  import branchPkg::*;

  logic  full;
  instrT instr;
  // saved prediction out of pfb0, saved predict flag out of dcd
  logic  pred;
  // direction the branch was given in pfb0, only carried from dcd to exe
  logic  fromPfb0;

  modport src (output full, output instr, output pred, output fromPfb0);
  modport dst (input full, input instr, input pred, input fromPfb0);
endinterface

// register updates still in flight in exe, fed back to pfb0 and dcd
interface exePendIf;
  logic lrUpdate;
  logic ctrUpForBcctr;
  logic mtCtr;
  logic crUpdate;

  modport src (output lrUpdate, output ctrUpForBcctr, output mtCtr, output crUpdate);
  modport dst (input lrUpdate, input ctrUpForBcctr, input mtCtr, input crUpdate);
endinterface

`default_nettype wire

//--- testbench/branchChecker.sv
`timescale 1ns/1ps
`default_nettype none

// compares the four DUT outputs with the expected columns of the current row
module branchChecker (
  input  logic clk,
  input  logic checkEn,
  input  logic rowLast,
  input  int   testNum,
  input  logic expPt,
  input  logic expDc,
  input  logic expEc,
  input  logic expBtc,
  input  logic pfb0Target,
  input  logic dcdCorrect,
  input  logic exeCorrect,
  input  logic branchTarCrt,
  output int   passCount,
  output int   failCount
);

  int passTotal  = 0;
  int failTotal  = 0;
  // mismatches seen so far in the running test
  int testErrors = 0;

  assign passCount = passTotal;
  assign failCount = failTotal;

  task automatic compareBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal)
    begin
      $display("[FAIL] t=%0t %s expected %0b actual %0b", $time, name, expVal, actVal);
      testErrors++;
    end
  endtask

  ////////////////////////////////////////
  // sampling on the falling edge
  ////////////////////////////////////////

  // inputs change on the rising edge, so mid-cycle the outputs are settled
  always @(negedge clk)
  begin
    if (checkEn)
    begin
      compareBit("pfb0Target", expPt, pfb0Target);
      compareBit("dcdCorrect", expDc, dcdCorrect);
      compareBit("exeCorrect", expEc, exeCorrect);
      compareBit("branchTarCrt", expBtc, branchTarCrt);
      // the marker row closes a test
      if (rowLast)
      begin
        if (testErrors == 0)
        begin
          $display("test %0d ok", testNum);
          passTotal++;
        end
        else
        begin
          $display("test %0d failed with %0d mismatches", testNum, testErrors);
          failTotal++;
        end
        testErrors = 0;
      end
    end
  end

  task automatic reportTotals();
    $display("tests passed %0d, tests failed %0d", passTotal, failTotal);
  endtask

endmodule

`default_nettype wire

//--- testbench/tbBranchPipe.sv
`timescale 1ns/1ps
`default_nettype none

module tbBranchPipe;
  import branchPkg::*;

  localparam int maxRows   = 80;
  localparam int clkPeriod = 8;

  logic  clk;
  logic  rst;
  logic  fetchValid;
  instrT fetchInstr;
  logic  hold;
  logic  flush;
  logic  dcdCondOk;
  logic  exeCondOk;
  logic  pfb0Target;
  logic  dcdCorrect;
  logic  exeCorrect;
  logic  branchTarCrt;

  // the stimulus table holds one row per cycle with the outputs expected in that cycle
  logic  tValid [maxRows];
  instrT tInstr [maxRows];
  logic  tHold  [maxRows];
  logic  tFlush [maxRows];
  logic  tDOk   [maxRows];
  logic  tEOk   [maxRows];
  logic  ePt    [maxRows];
  logic  eDc    [maxRows];
  logic  eEc    [maxRows];
  logic  tLast  [maxRows];
  int    tTest  [maxRows];

  int   nRows;
  int   nTests;
  int   base;
  int   passCount;
  int   failCount;
  logic tableReady = 1'b0;

  logic checkEn;
  logic rowLast;
  int   testNum;
  logic expPt;
  logic expDc;
  logic expEc;
  logic expBtc;

  branchPipe uut (
    .clk          (clk),
    .rst          (rst),
    .fetchValid   (fetchValid),
    .fetchInstr   (fetchInstr),
    .hold         (hold),
    .flush        (flush),
    .dcdCondOk    (dcdCondOk),
    .exeCondOk    (exeCondOk),
    .pfb0Target   (pfb0Target),
    .dcdCorrect   (dcdCorrect),
    .exeCorrect   (exeCorrect),
    .branchTarCrt (branchTarCrt)
  );

  branchChecker chk (
    .clk          (clk),
    .checkEn      (checkEn),
    .rowLast      (rowLast),
    .testNum      (testNum),
    .expPt        (expPt),
    .expDc        (expDc),
    .expEc        (expEc),
    .expBtc       (expBtc),
    .pfb0Target   (pfb0Target),
    .dcdCorrect   (dcdCorrect),
    .exeCorrect   (exeCorrect),
    .branchTarCrt (branchTarCrt),
    .passCount    (passCount),
    .failCount    (failCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // instruction builders
  ////////////////////////////////////////

  // no flags are set and sprn and the unused BO bits are random filler
  function automatic instrT plainInstr();
    instrT       ins;
    logic [31:0] rnd;
    rnd      = $urandom();
    ins      = '0;
    ins.sprn = rnd[9:0];
    ins.bo   = rnd[14:10];
    return ins;
  endfunction

  // viaReg makes it a bclr or a bcctr and ctr picks the bcctr
  function automatic instrT bcInstr(input logic bo0, input logic bo2, input logic bo4,
                                    input logic bd0, input logic viaReg, input logic ctr);
    instrT ins;
    ins        = plainInstr();
    ins.isBc   = 1'b1;
    ins.bo[0]  = bo0;
    ins.bo[2]  = bo2;
    ins.bo[4]  = bo4;
    ins.bd0    = bd0;
    ins.priOp5 = viaReg;
    ins.secOp0 = ctr;
    return ins;
  endfunction

  function automatic instrT mtsprInstr(input sprnT num);
    instrT ins;
    ins         = plainInstr();
    ins.isMtspr = 1'b1;
    ins.sprn    = num;
    return ins;
  endfunction

  // the static guess is taken when BO0 and BO2 are both set or when BD0 differs from BO4
  function automatic logic staticPred(input logic bo0, input logic bo2, input logic bo4,
                                      input logic bd0);
    return (bo0 & bo2) | (bd0 ^ bo4);
  endfunction

  task automatic setFetch(input int idx, input instrT ins);
    tValid[idx] = 1'b1;
    tInstr[idx] = ins;
  endtask

  // tags the rows of the test and puts the marker on its last row
  task automatic closeTest(input int len);
    int r;
    nTests++;
    for (r = 0; r < len; r++)
      tTest[base + r] = nTests;
    base = base + len;
    tLast[base - 1] = 1'b1;
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  task automatic buildTable();
    int         r;
    int         k;
    logic [3:0] c;
    logic       p;
    instrT      ins;
    base   = 0;
    nTests = 0;
    for (r = 0; r < maxRows; r++)
    begin
      tValid[r] = 1'b0;
      tInstr[r] = plainInstr();
      tHold[r]  = 1'b0;
      tFlush[r] = 1'b0;
      tDOk[r]   = 1'b0;
      tEOk[r]   = 1'b0;
      ePt[r]    = 1'b0;
      eDc[r]    = 1'b0;
      eEc[r]    = 1'b0;
      tLast[r]  = 1'b0;
      tTest[r]  = 0;
    end

    // the first row checks the quiet outputs after reset and then a plain branch redirects
    ins = plainInstr();
    ins.isB = 1'b1;
    setFetch(base, ins);
    ePt[base + 1] = 1'b1;
    closeTest(4);

    // all sixteen BO0/BO2/BO4/BD0 combinations back to back,
    // dcd condition matches the guess so nothing gets corrected
    for (k = 0; k < 16; k++)
    begin
      c = k[3:0];
      p = staticPred(c[3], c[2], c[1], c[0]);
      setFetch(base + k, bcInstr(c[3], c[2], c[1], c[0], 1'b0, 1'b0));
      ePt[base + k + 1] = p;
      tDOk[base + k + 2] = p;
    end
    closeTest(19);

    // a bclr right behind an mtspr to LR sees LR pending in dcd and then in exe
    setFetch(base, mtsprInstr(sprLr));
    setFetch(base + 1, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
    tDOk[base + 3] = 1'b1;
    tEOk[base + 4] = 1'b1;
    eEc[base + 4]  = 1'b1;
    closeTest(5);

    // with one bubble between them the mtspr is in exe when the bclr sits in pfb0
    setFetch(base, mtsprInstr(sprLr));
    setFetch(base + 2, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
    tDOk[base + 4] = 1'b1;
    eDc[base + 4]  = 1'b1;
    closeTest(6);

    // a bc with BO2 clear decrements CTR and the bcctr behind it is vetoed
    setFetch(base, bcInstr(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    ePt[base + 1] = 1'b1;
    setFetch(base + 1, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
    tDOk[base + 2] = 1'b1;
    tDOk[base + 3] = 1'b1;
    tEOk[base + 4] = 1'b1;
    eEc[base + 4]  = 1'b1;
    closeTest(5);

    // resolved in dcd so a correction comes exactly when guess and condition differ
    for (k = 0; k < 4; k++)
    begin
      c = k[3:0];
      setFetch(base + k, bcInstr(c[1], 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
      ePt[base + k + 1]  = staticPred(c[1], 1'b1, 1'b0, 1'b0);
      tDOk[base + k + 2] = c[0];
      eDc[base + k + 2]  = staticPred(c[1], 1'b1, 1'b0, 1'b0) ^ c[0];
    end
    closeTest(7);

    // CR is still being written by exe so dcd predicts and exe settles it
    ins = plainInstr();
    ins.updatesCr = 1'b1;
    setFetch(base, ins);
    setFetch(base + 1, bcInstr(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
    ePt[base + 2]  = 1'b1;
    tEOk[base + 4] = 1'b0;
    eEc[base + 4]  = 1'b1;
    setFetch(base + 2, ins);
    setFetch(base + 3, bcInstr(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
    tDOk[base + 5] = 1'b1;
    closeTest(7);

    // over three held cycles each stage fires only in its first cycle
    setFetch(base, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    setFetch(base + 1, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    ePt[base + 1] = 1'b1;
    ePt[base + 2] = 1'b1;
    eDc[base + 2] = 1'b1;
    for (k = 2; k < 5; k++)
      tHold[base + k] = 1'b1;
    eDc[base + 6] = 1'b1;
    closeTest(8);

    // the flushed branch would be corrected in dcd if it ever got there
    setFetch(base, bcInstr(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    ePt[base + 1]    = 1'b1;
    tFlush[base + 1] = 1'b1;
    // this one would predict behind the CR update and be corrected in exe
    // because exeCondOk stays low against its taken guess
    ins = plainInstr();
    ins.updatesCr = 1'b1;
    setFetch(base + 2, ins);
    setFetch(base + 3, bcInstr(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
    ePt[base + 4]    = 1'b1;
    tFlush[base + 4] = 1'b1;
    closeTest(7);

    nRows = base;
  endtask

  ////////////////////////////////////////
  // run
  ////////////////////////////////////////
  initial
  begin
    int r;
    // the random filler is seeded once before the table is built
    void'($urandom(10));
    rst        = 1'b1;
    fetchValid = 1'b0;
    fetchInstr = '0;
    hold       = 1'b0;
    flush      = 1'b0;
    dcdCondOk  = 1'b0;
    exeCondOk  = 1'b0;
    checkEn    = 1'b0;
    rowLast    = 1'b0;
    testNum    = 0;
    expPt      = 1'b0;
    expDc      = 1'b0;
    expEc      = 1'b0;
    expBtc     = 1'b0;
    buildTable();
    tableReady = 1'b1;

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (r = 0; r < nRows; r++)
    begin
      fetchValid <= tValid[r];
      fetchInstr <= tInstr[r];
      hold       <= tHold[r];
      flush      <= tFlush[r];
      dcdCondOk  <= tDOk[r];
      exeCondOk  <= tEOk[r];
      expPt      <= ePt[r];
      expDc      <= eDc[r];
      expEc      <= eEc[r];
      // fetch redirects whenever any stage targets or corrects
      expBtc     <= ePt[r] | eDc[r] | eEc[r];
      rowLast    <= tLast[r];
      testNum    <= tTest[r];
      checkEn    <= 1'b1;
      @(posedge clk);
    end
    checkEn    <= 1'b0;
    fetchValid <= 1'b0;
    @(negedge clk);

    chk.reportTotals();
    if (failCount == 0 && passCount == nTests)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // the table length and the two reset cycles fix the run time and twenty spare cycles go on top
  initial
  begin
    wait (tableReady);
    #((nRows + 22) * clkPeriod);
    $display("timeout: the stimulus table was not finished in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
